//--- design/fighterPkg.sv
package fighterPkg;

    //////////////////////////////
    // Button and status types
    //////////////////////////////

    // Step code used by the combo sequences
    typedef enum logic [1:0] {
        dirUp    = 2'd0,
        dirDown  = 2'd1,
        dirLeft  = 2'd2,
        dirRight = 2'd3
    } direction_t;

    // Raw or debounced push buttons
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic attack;
        logic block;
    } buttonState_t;

    // Reported by the game state
    typedef struct packed {
        logic isCrouched;
        logic isInAir;
        logic isStunned;
        logic isPerformingAttackAnimation;
    } fighterStatus_t;

    typedef struct packed {
        logic       left;
        logic       right;
        logic       up;
        logic       down;
        logic [1:0] attack;
    } botCommand_t;

    // One-cycle success pulses
    typedef struct packed {
        logic special;
        logic superSpecial;
    } comboFlags_t;

    typedef struct packed {
        logic       isCrouching;
        logic       movingLeft;
        logic       movingRight;
        logic       isJumping;
        logic       isBlocking;
        logic [1:0] comboMove;
    } actionOutput_t;

    localparam int BUTTON_COUNT = $bits(buttonState_t);

    //////////////////////////////
    // Attack codes
    //////////////////////////////

    localparam logic [1:0] ATTACK_NONE    = 2'd0;
    localparam logic [1:0] ATTACK_NORMAL  = 2'd1;
    localparam logic [1:0] ATTACK_SPECIAL = 2'd2;
    localparam logic [1:0] ATTACK_SUPER   = 2'd3;

    //////////////////////////////
    // Timing
    //////////////////////////////

    localparam int DEBOUNCE_CYCLES      = 4;
    localparam int DEBOUNCE_COUNT_WIDTH = $clog2(DEBOUNCE_CYCLES);

    // Max cycles between two consecutive combo steps
    localparam int COMBO_WINDOW      = 16;
    localparam int COMBO_COUNT_WIDTH = $clog2(COMBO_WINDOW + 1);

    // Direction steps only, attack closes every combo
    localparam int SPECIAL_LENGTH = 3;
    localparam direction_t [0:SPECIAL_LENGTH-1] SPECIAL_SEQUENCE =
        '{dirLeft, dirDown, dirRight};

    localparam int SUPER_LENGTH = 8;
    localparam direction_t [0:SUPER_LENGTH-1] SUPER_SEQUENCE =
        '{dirUp, dirUp, dirDown, dirDown, dirLeft, dirRight, dirLeft, dirRight};

    //////////////////////////////
    // Computer opponent
    //////////////////////////////

    localparam int MOVE_PERIOD        = 22;
    localparam int MOVE_COUNT_WIDTH   = $clog2(MOVE_PERIOD);
    localparam int HEALTH_THRESHOLD   = 154;
    localparam int ATTACK_PERIOD_HIGH = 7;
    localparam int ATTACK_PERIOD_LOW  = 3;
    localparam int ATTACK_COUNT_WIDTH = $clog2(ATTACK_PERIOD_HIGH);

    // Random thresholds, a value strictly above the limit selects the action
    localparam int RANDOM_LEFT_LIMIT    = 15;
    localparam int RANDOM_SUPER_VALUE   = 30;
    localparam int RANDOM_SPECIAL_LIMIT = 26;
    localparam int RANDOM_NORMAL_LIMIT  = 6;
    localparam int RANDOM_JUMP_LIMIT    = 28;
    localparam int RANDOM_CROUCH_LIMIT  = 29;

endpackage

//--- design/buttonDebouncer.sv
`timescale 1ns/10ps

module buttonDebouncer import fighterPkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  buttonState_t raw,
    output buttonState_t debounced
);

    logic [BUTTON_COUNT-1:0]         rawBits;
    logic [BUTTON_COUNT-1:0]         levelBits;
    logic [DEBOUNCE_COUNT_WIDTH-1:0] stableCount [BUTTON_COUNT];

    assign rawBits   = raw;
    assign debounced = levelBits;

    //////////////////////////////
    // Per-button stability counters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            levelBits <= '0;
            for (int i = 0; i < BUTTON_COUNT; i++) begin
                stableCount[i] <= '0;
            end
        end else begin
            for (int i = 0; i < BUTTON_COUNT; i++) begin
                if (rawBits[i] == levelBits[i]) begin
                    // Raw agrees with the level
                    stableCount[i] <= '0;
                end else if (stableCount[i] == DEBOUNCE_COUNT_WIDTH'(DEBOUNCE_CYCLES - 1)) begin
                    // Enough equal samples in a row
                    levelBits[i]   <= rawBits[i];
                    stableCount[i] <= '0;
                end else begin
                    stableCount[i] <= stableCount[i] + 1'b1;
                end
            end
        end
    end

endmodule

//--- design/comboDetector.sv
`timescale 1ns/10ps

module comboDetector import fighterPkg::*; #(
    parameter int SEQ_LENGTH = SPECIAL_LENGTH,
    parameter direction_t [0:SEQ_LENGTH-1] SEQUENCE = SPECIAL_SEQUENCE
) (
    input  logic         clk,
    input  logic         reset,
    input  buttonState_t debounced,
    output logic         success
);

    buttonState_t                    prevLevels;
    buttonState_t                    pressEvent;
    logic                            dirEvent;
    direction_t                      dirCode;
    logic [$clog2(SEQ_LENGTH+1)-1:0] stepIndex;
    logic [$clog2(SEQ_LENGTH+1)-1:0] baseIndex;
    logic [COMBO_COUNT_WIDTH-1:0]    windowCount;
    logic                            windowExpired;
    logic                            stepMatch;

    //////////////////////////////
    // Press events
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            prevLevels <= '0;
            pressEvent <= '0;
        end else begin
            prevLevels <= debounced;
            pressEvent <= debounced & ~prevLevels;
        end
    end

    // Only one direction per cycle, up wins
    always_comb begin
        dirEvent = pressEvent.up | pressEvent.down | pressEvent.left | pressEvent.right;
        if (pressEvent.up) begin
            dirCode = dirUp;
        end else if (pressEvent.down) begin
            dirCode = dirDown;
        end else if (pressEvent.left) begin
            dirCode = dirLeft;
        end else begin
            dirCode = dirRight;
        end
    end

    //////////////////////////////
    // Sequence matcher
    //////////////////////////////

    // An expired window acts as if the match had already restarted
    always_comb begin
        windowExpired = (stepIndex != '0) && (windowCount == COMBO_COUNT_WIDTH'(COMBO_WINDOW));
        baseIndex     = windowExpired ? '0 : stepIndex;
        stepMatch     = (baseIndex < SEQ_LENGTH) && (SEQUENCE[baseIndex] == dirCode);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stepIndex   <= '0;
            windowCount <= '0;
            success     <= 1'b0;
        end else begin
            success <= 1'b0;
            if (dirEvent) begin
                windowCount <= '0;
                if (stepMatch) begin
                    stepIndex <= baseIndex + 1'b1;
                end else if (dirCode == SEQUENCE[0]) begin
                    stepIndex <= 1'b1;
                end else begin
                    stepIndex <= '0;
                end
            end else if (pressEvent.attack) begin
                // Attack closes the sequence either way
                success     <= (baseIndex == SEQ_LENGTH);
                stepIndex   <= '0;
                windowCount <= '0;
            end else if (windowExpired) begin
                stepIndex   <= '0;
                windowCount <= '0;
            end else if (stepIndex != '0) begin
                windowCount <= windowCount + 1'b1;
            end
        end
    end

endmodule

//--- design/botController.sv
`timescale 1ns/10ps

module botController import fighterPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        gameTick,
    input  logic        bypass,
    input  logic [4:0]  random5bit,
    input  logic [7:0]  health,
    output botCommand_t command
);

    logic [MOVE_COUNT_WIDTH-1:0]   moveCount;
    logic [ATTACK_COUNT_WIDTH-1:0] attackCount;
    logic [ATTACK_COUNT_WIDTH-1:0] attackLast;
    logic                          tickActive;
    logic                          moveWrap;
    logic                          attackWrap;
    logic [1:0]                    attackChoice;

    //////////////////////////////
    // Tick counters
    //////////////////////////////

    always_comb begin
        tickActive = gameTick && bypass;
        // Low health makes the bot attack more often
        attackLast = (health > 8'(HEALTH_THRESHOLD)) ?
                     ATTACK_COUNT_WIDTH'(ATTACK_PERIOD_HIGH - 1) :
                     ATTACK_COUNT_WIDTH'(ATTACK_PERIOD_LOW - 1);
        moveWrap   = (moveCount == MOVE_COUNT_WIDTH'(MOVE_PERIOD - 1));
        // Greater or equal so a period drop mid count still wraps
        attackWrap = (attackCount >= attackLast);
    end

    // Attack strength from the random value
    always_comb begin
        if (random5bit == 5'(RANDOM_SUPER_VALUE)) begin
            attackChoice = ATTACK_SUPER;
        end else if (random5bit > 5'(RANDOM_SPECIAL_LIMIT)) begin
            attackChoice = ATTACK_SPECIAL;
        end else if (random5bit > 5'(RANDOM_NORMAL_LIMIT)) begin
            attackChoice = ATTACK_NORMAL;
        end else begin
            attackChoice = ATTACK_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            moveCount   <= '0;
            attackCount <= '0;
            command     <= '0;
        end else if (tickActive) begin
            moveCount   <= moveWrap ? '0 : moveCount + 1'b1;
            attackCount <= attackWrap ? '0 : attackCount + 1'b1;
            if (moveWrap) begin
                command.left  <= (random5bit > 5'(RANDOM_LEFT_LIMIT));
                command.right <= !(random5bit > 5'(RANDOM_LEFT_LIMIT));
            end
            // Jump and crouch go with attacks so the bot does not hop every move
            if (attackWrap) begin
                command.attack <= attackChoice;
                command.up     <= (random5bit > 5'(RANDOM_JUMP_LIMIT));
                command.down   <= (random5bit > 5'(RANDOM_CROUCH_LIMIT));
            end
        end
    end

endmodule

//--- design/actionArbiter.sv
`timescale 1ns/10ps

module actionArbiter import fighterPkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           bypass,
    input  buttonState_t   debounced,
    input  comboFlags_t    combos,
    input  botCommand_t    command,
    input  fighterStatus_t status,
    output actionOutput_t  action
);

    logic          canAct;
    logic          canMoveVertical;
    actionOutput_t nextAction;

    //////////////////////////////
    // Status gating
    //////////////////////////////

    always_comb begin
        canAct          = !(status.isStunned || status.isPerformingAttackAnimation);
        canMoveVertical = canAct && !(status.isInAir || status.isCrouched);
    end

    always_comb begin
        nextAction = '0;
        if (bypass) begin
            // Bot drives, no blocking
            nextAction.movingLeft  = canAct && command.left;
            nextAction.movingRight = canAct && command.right;
            nextAction.isJumping   = canMoveVertical && command.up;
            nextAction.isCrouching = canMoveVertical && command.down;
            nextAction.isBlocking  = 1'b0;
            nextAction.comboMove   = command.attack;
        end else begin
            nextAction.movingLeft  = canAct && debounced.left;
            nextAction.movingRight = canAct && debounced.right;
            nextAction.isJumping   = canMoveVertical && debounced.up;
            nextAction.isCrouching = canMoveVertical && debounced.down;
            nextAction.isBlocking  = canAct && debounced.block;
            // Stronger attack always wins
            if (!canAct) begin
                nextAction.comboMove = ATTACK_NONE;
            end else if (combos.superSpecial) begin
                nextAction.comboMove = ATTACK_SUPER;
            end else if (combos.special) begin
                nextAction.comboMove = ATTACK_SPECIAL;
            end else if (debounced.attack) begin
                nextAction.comboMove = ATTACK_NORMAL;
            end else begin
                nextAction.comboMove = ATTACK_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            action <= '0;
        end else begin
            action <= nextAction;
        end
    end

endmodule

//--- design/fighterControlTop.sv
`timescale 1ns/10ps

module fighterControlTop import fighterPkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  buttonState_t   buttonsRaw,
    input  fighterStatus_t status,
    input  logic [7:0]     health,
    input  logic           bypass,
    input  logic           gameTick,
    input  logic [4:0]     random5bit,
    output actionOutput_t  action
);

    buttonState_t debounced;
    comboFlags_t  combos;
    botCommand_t  command;

    //////////////////////////////
    // Player input path
    //////////////////////////////

    buttonDebouncer debouncer (
        .clk       (clk),
        .reset     (reset),
        .raw       (buttonsRaw),
        .debounced (debounced)
    );

    // Left, down, right, attack
    comboDetector #(
        .SEQ_LENGTH (SPECIAL_LENGTH),
        .SEQUENCE   (SPECIAL_SEQUENCE)
    ) specialDetector (
        .clk       (clk),
        .reset     (reset),
        .debounced (debounced),
        .success   (combos.special)
    );

    // Konami directions, then attack
    comboDetector #(
        .SEQ_LENGTH (SUPER_LENGTH),
        .SEQUENCE   (SUPER_SEQUENCE)
    ) superDetector (
        .clk       (clk),
        .reset     (reset),
        .debounced (debounced),
        .success   (combos.superSpecial)
    );

    //////////////////////////////
    // Bot and arbitration
    //////////////////////////////

    botController bot (
        .clk        (clk),
        .reset      (reset),
        .gameTick   (gameTick),
        .bypass     (bypass),
        .random5bit (random5bit),
        .health     (health),
        .command    (command)
    );

    actionArbiter arbiter (
        .clk       (clk),
        .reset     (reset),
        .bypass    (bypass),
        .debounced (debounced),
        .combos    (combos),
        .command   (command),
        .status    (status),
        .action    (action)
    );

endmodule

//--- verif/clockGen.sv
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic reset
);

    localparam time HALF_PERIOD = 50;
    localparam time DRIVE_DELAY = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset spans three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
    end

endmodule

//--- verif/fighterControl_sva.sv
`timescale 1ns/10ps

module fighterControlSva import fighterPkg::*; (
    input logic           clk,
    input logic           reset,
    input fighterStatus_t status,
    input logic           bypass,
    input logic           gameTick,
    input actionOutput_t  action
);

    int assertFailures = 0;

    //////////////////////////////
    // Reset and status gating
    //////////////////////////////

    resetClear: assert property (@(posedge clk) reset |=> action == '0)
    else begin
        assertFailures++;
        $error("action fields not zero after a reset cycle");
    end

    // Bot attack code is not gated
    stunGating: assert property (@(posedge clk) disable iff (reset)
        $past(status.isStunned || status.isPerformingAttackAnimation) |->
            !(action.movingLeft || action.movingRight || action.isJumping ||
              action.isCrouching || action.isBlocking) &&
            ($past(bypass) || action.comboMove == ATTACK_NONE))
    else begin
        assertFailures++;
        $error("move, block or attack active while stunned or attacking");
    end

    verticalGating: assert property (@(posedge clk) disable iff (reset)
        $past(status.isInAir || status.isCrouched) |->
            !action.isJumping && !action.isCrouching)
    else begin
        assertFailures++;
        $error("jump or crouch active while in air or crouched");
    end

    //////////////////////////////
    // Computer opponent
    //////////////////////////////

    botNoBlock: assert property (@(posedge clk) disable iff (reset)
        $past(bypass) |-> !action.isBlocking)
    else begin
        assertFailures++;
        $error("block active with the bot in control");
    end

    botOneDirection: assert property (@(posedge clk) disable iff (reset)
        $past(bypass) |-> !(action.movingLeft && action.movingRight))
    else begin
        assertFailures++;
        $error("bot moves left and right at once");
    end

    // Command updates on the tick edge, the arbiter adds one more
    botHoldsBetweenTicks: assert property (@(posedge clk) disable iff (reset)
        ($past(bypass, 1) && $past(bypass, 2) && !$past(reset, 2) &&
         $past(status, 1) == $past(status, 2) && !$past(gameTick, 2)) |->
            $stable(action))
    else begin
        assertFailures++;
        $error("bot action changed without a game tick");
    end

endmodule

bind fighterControlTop fighterControlSva sva (
    .clk      (clk),
    .reset    (reset),
    .status   (status),
    .bypass   (bypass),
    .gameTick (gameTick),
    .action   (action)
);

//--- verif/fighterControlTb.sv
`timescale 1ns/10ps

module fighterControlTb import fighterPkg::*; ();

    localparam time DRIVE_DELAY = 10;
    localparam int  STEP_HOLD   = 5;
    localparam int  WAIT_LIMIT  = 20;
    // Six attack periods at high health before the drop to low health
    localparam int  HIGH_HEALTH_TICKS = 6 * ATTACK_PERIOD_HIGH;
    localparam int  BOT_TICKS         = 3 * MOVE_PERIOD;

    logic           clk;
    logic           reset;
    buttonState_t   buttonsRaw;
    fighterStatus_t status;
    logic [7:0]     health;
    logic           bypass;
    logic           gameTick;
    logic [4:0]     random5bit;
    actionOutput_t  action;
    int             errorCount = 0;
    integer         seed = 32'h3d51_8365;
    direction_t     steps[$];

    clockGen clocks (
        .clk   (clk),
        .reset (reset)
    );

    fighterControlTop uut (
        .clk        (clk),
        .reset      (reset),
        .buttonsRaw (buttonsRaw),
        .status     (status),
        .health     (health),
        .bypass     (bypass),
        .gameTick   (gameTick),
        .random5bit (random5bit),
        .action     (action)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic nextCycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic reportMismatch(input string what, input int got, input int want);
        errorCount++;
        $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
    endtask

    task automatic waitForAction(input actionOutput_t want, input int limit,
                                 output int cycles);
        cycles = 0;
        while (action != want && cycles < limit) begin
            nextCycle();
            cycles++;
        end
        if (action != want) begin
            errorCount++;
            $display("Timeout at %0t ns: action never reached %0h within %0d cycles",
                     $time, want, limit);
        end
    endtask

    task automatic settle();
        int cycles;
        buttonsRaw = '0;
        status     = '0;
        waitForAction('0, WAIT_LIMIT, cycles);
    endtask

    function automatic logic [4:0] randomBits();
        integer word;
        word = $random(seed);
        return word[4:0];
    endfunction

    function automatic buttonState_t randomButtons();
        integer word;
        word = $random(seed);
        return buttonState_t'(word[5:0]);
    endfunction

    function automatic buttonState_t buttonFor(input direction_t dir);
        buttonState_t pressed;
        pressed = '0;
        case (dir)
            dirUp:   pressed.up    = 1'b1;
            dirDown: pressed.down  = 1'b1;
            dirLeft: pressed.left  = 1'b1;
            default: pressed.right = 1'b1;
        endcase
        return pressed;
    endfunction

    // Bot attack strength for one random sample
    function automatic logic [1:0] expectedAttack(input logic [4:0] r);
        logic [1:0] code;
        if (r == 5'd30) begin
            code = ATTACK_SUPER;
        end else if (r > 5'd26) begin
            code = ATTACK_SPECIAL;
        end else if (r > 5'd6) begin
            code = ATTACK_NORMAL;
        end else begin
            code = ATTACK_NONE;
        end
        return code;
    endfunction

    //////////////////////////////
    // Scenarios
    //////////////////////////////

    task automatic checkReset();
        int cycles;
        cycles = 0;
        @(posedge clk);
        do begin
            @(negedge clk);
            assert (action == '0) else reportMismatch("action in reset", int'(action), 0);
            cycles++;
        end while (reset && cycles < 10);
        if (reset) begin
            errorCount++;
            $display("Timeout: reset was never released");
        end
        nextCycle();
        assert (action == '0) else reportMismatch("action after reset", int'(action), 0);
    endtask

    // No run of equal samples reaches the debounce length
    task automatic checkGlitches();
        logic [15:0] glitchPattern;
        glitchPattern = 16'b1110_0110_1110_1101;
        for (int i = 15; i >= 0; i--) begin
            buttonsRaw.attack = glitchPattern[i];
            buttonsRaw.left   = glitchPattern[i];
            nextCycle();
            assert (action == '0) else reportMismatch("action on glitch", int'(action), 0);
        end
        buttonsRaw = '0;
        repeat (6) begin
            nextCycle();
            assert (action == '0) else reportMismatch("action on glitch", int'(action), 0);
        end
    endtask

    // Every button held so each gated field is active before the status flags
    task automatic checkGating();
        actionOutput_t want;
        int            cycles;
        buttonsRaw     = '1;
        want           = '1;
        want.comboMove = ATTACK_NORMAL;
        waitForAction(want, WAIT_LIMIT, cycles);
        status.isStunned = 1'b1;
        nextCycle();
        assert (action == '0) else reportMismatch("action while stunned", int'(action), 0);
        repeat (2) nextCycle();
        status = '0;
        status.isPerformingAttackAnimation = 1'b1;
        repeat (3) nextCycle();
        status = '0;
        status.isInAir = 1'b1;
        repeat (3) nextCycle();
        status = '0;
        status.isCrouched = 1'b1;
        repeat (3) nextCycle();
        status = '0;
        waitForAction(want, STEP_HOLD, cycles);
        settle();
    endtask

    // Extra rest before the last step opens a gap in the sequence
    task automatic playCombo(input direction_t seq[$], input int gapCycles,
                             input logic [1:0] code);
        actionOutput_t want;
        int            cycles;
        int            latency;
        foreach (seq[i]) begin
            if (i == seq.size() - 1) begin
                repeat (gapCycles) nextCycle();
            end
            buttonsRaw = buttonFor(seq[i]);
            repeat (STEP_HOLD) nextCycle();
            buttonsRaw = '0;
            repeat (STEP_HOLD) nextCycle();
        end
        buttonsRaw.attack = 1'b1;
        want              = '0;
        want.comboMove    = code;
        latency = (code == ATTACK_NORMAL) ? DEBOUNCE_CYCLES + 1 : DEBOUNCE_CYCLES + 3;
        waitForAction(want, WAIT_LIMIT, cycles);
        assert (cycles == latency) else reportMismatch("combo latency", cycles, latency);
        // Held attack falls back to a normal attack
        repeat ((code == ATTACK_NORMAL) ? 3 : 1) begin
            nextCycle();
            assert (action.comboMove == ATTACK_NORMAL)
                else reportMismatch("comboMove", action.comboMove, ATTACK_NORMAL);
        end
        settle();
    endtask

    task automatic runBotPhase();
        actionOutput_t want;
        logic [4:0]    r;
        int            moveTicks;
        int            attackTicks;
        int            attackPeriod;
        want        = '0;
        moveTicks   = 0;
        attackTicks = 0;
        bypass      = 1'b1;
        health      = 8'd200;
        for (int t = 0; t < BOT_TICKS; t++) begin
            if (t == HIGH_HEALTH_TICKS) begin
                health = 8'd100;
            end
            attackPeriod = (health > HEALTH_THRESHOLD) ? ATTACK_PERIOD_HIGH : ATTACK_PERIOD_LOW;
            r          = randomBits();
            gameTick   = 1'b1;
            random5bit = r;
            buttonsRaw = randomButtons();
            nextCycle();
            gameTick   = 1'b0;
            random5bit = randomBits();
            buttonsRaw = randomButtons();
            moveTicks++;
            if (moveTicks == MOVE_PERIOD) begin
                moveTicks        = 0;
                want.movingLeft  = (r > 5'd15);
                want.movingRight = !(r > 5'd15);
            end
            attackTicks++;
            if (attackTicks == attackPeriod) begin
                attackTicks      = 0;
                want.comboMove   = expectedAttack(r);
                want.isJumping   = (r > 5'd28);
                want.isCrouching = (r > 5'd29);
            end
            nextCycle();
            assert (action == want) else reportMismatch("bot action", int'(action), int'(want));
            random5bit = randomBits();
            buttonsRaw = randomButtons();
            repeat (randomBits() % 3) begin
                nextCycle();
                random5bit = randomBits();
                buttonsRaw = randomButtons();
            end
            nextCycle();
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        actionOutput_t want;
        int            cycles;
        buttonsRaw = '0;
        status     = '0;
        health     = 8'd200;
        bypass     = 1'b0;
        gameTick   = 1'b0;
        random5bit = '0;
        checkReset();
        checkGlitches();

        buttonsRaw.attack = 1'b1;
        want              = '0;
        want.comboMove    = ATTACK_NORMAL;
        waitForAction(want, WAIT_LIMIT, cycles);
        assert (cycles == DEBOUNCE_CYCLES + 1)
            else reportMismatch("attack latency", cycles, DEBOUNCE_CYCLES + 1);
        settle();

        checkGating();

        steps = '{dirLeft, dirDown, dirRight};
        playCombo(steps, 0, ATTACK_SPECIAL);
        steps = '{dirUp, dirUp, dirDown, dirDown, dirLeft, dirRight, dirLeft, dirRight};
        playCombo(steps, 0, ATTACK_SUPER);
        steps = '{dirLeft, dirDown, dirRight};
        playCombo(steps, 25, ATTACK_NORMAL);

        runBotPhase();

        $display("Closing: %0d testbench errors, %0d assertion failures",
                 errorCount, uut.sva.assertFailures);
        if (errorCount == 0 && uut.sva.assertFailures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- fighterControl.f
design/fighterPkg.sv
design/buttonDebouncer.sv
design/comboDetector.sv
design/botController.sv
design/actionArbiter.sv
design/fighterControlTop.sv
verif/clockGen.sv
verif/fighterControl_sva.sv
verif/fighterControlTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the fighterControl testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fighterControlSim
LOG_FILE=sim.log
PASS_TEXT="Finished with no errors"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fighterControlTb \
    -f fighterControl.f \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "$PASS_TEXT" "$LOG_FILE"; then
    echo "RESULT: PASS"
    exit 0
else
    echo "RESULT: FAIL"
    exit 1
fi
